/* include/xform_consts.svh */
`ifndef XFORM_CONSTS_SVH
`define XFORM_CONSTS_SVH

//////////////////////////////
// geometry unit widths
//////////////////////////////

// one matrix element or coordinate
`define XF_WORD_W    32

// operand RAM addressing
`define XF_ADDR_W    8
`define XF_RAM_DEPTH 256   // one word per address, full 8-bit space

// four elements side by side, element 0 in the top word
`define XF_VEC_W     128

`endif

/* design/xform_pkg.sv */
`default_nettype none

`include "xform_consts.svh"

package xform_pkg;

    typedef logic signed [`XF_WORD_W-1:0] word_t;   // matrix element / coordinate
    typedef logic [`XF_VEC_W-1:0]         vec4_t;   // row or vector, element 0 on top
    typedef logic [`XF_ADDR_W-1:0]        addr_t;   // operand RAM word address
    typedef logic [1:0]                   row_idx_t;

    typedef enum logic {
        MODE_MODELVIEW  = 1'b0,
        MODE_PROJECTION = 1'b1
    } mode_t;

    typedef enum logic {
        OP_VERTEX = 1'b0,   // 4x4 * 4x1
        OP_MATRIX = 1'b1    // 4x4 * 4x4
    } op_t;

    // transform engine states
    typedef enum logic [2:0] {
        IDLE,
        MAT_RUN,
        MAT_WRITE,
        VTX_EYE,
        VTX_CLIP,
        VTX_DONE
    } eng_state_t;

endpackage

`default_nettype wire

/* design/matrix_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "xform_consts.svh"

module matrix_regs (
    input  logic                 clk,
    input  logic                 arst_n,
    // host row write
    input  logic                 host_wr,
    input  xform_pkg::mode_t     host_mode,
    input  xform_pkg::row_idx_t  host_row,
    input  xform_pkg::vec4_t     host_data,
    // host readback
    input  xform_pkg::mode_t     rd_mode,
    input  xform_pkg::row_idx_t  rd_row,
    output xform_pkg::vec4_t     rd_data,
    // engine peek
    input  xform_pkg::mode_t     peek_mode,
    input  xform_pkg::row_idx_t  peek_row,
    output xform_pkg::vec4_t     peek_data,
    // engine whole-matrix write
    input  logic                 wr_en,
    input  xform_pkg::mode_t     wr_mode,
    input  xform_pkg::vec4_t     wr_row_0,
    input  xform_pkg::vec4_t     wr_row_1,
    input  xform_pkg::vec4_t     wr_row_2,
    input  xform_pkg::vec4_t     wr_row_3
);
    import xform_pkg::*;

    vec4_t mat_q [2][4];    // [mode][row]

    // row r of the identity matrix
    function automatic vec4_t ident_row(int r);
        vec4_t v;
        v = '0;
        v[(3 - r) * `XF_WORD_W +: `XF_WORD_W] = word_t'(1);
        return v;
    endfunction

    //////////////////////////////
    // storage
    //////////////////////////////
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int m = 0; m < 2; m++)
            begin
                for (int r = 0; r < 4; r++)
                begin
                    mat_q[m][r] <= ident_row(r);
                end
            end
        end
        else
        begin
            if (host_wr)
            begin
                mat_q[host_mode][host_row] <= host_data;
            end
            // engine write comes last so it wins on a clash
            if (wr_en)
            begin
                mat_q[wr_mode][0] <= wr_row_0;
                mat_q[wr_mode][1] <= wr_row_1;
                mat_q[wr_mode][2] <= wr_row_2;
                mat_q[wr_mode][3] <= wr_row_3;
            end
        end
    end

    // two independent read ports
    assign rd_data   = mat_q[rd_mode][rd_row];
    assign peek_data = mat_q[peek_mode][peek_row];   // engine operand row

endmodule

`default_nettype wire

/* design/operand_ram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "xform_consts.svh"

module operand_ram (
    input  logic              clk,
    input  logic              wr,
    input  xform_pkg::addr_t  wr_addr,
    input  xform_pkg::word_t  wr_data,
    input  xform_pkg::addr_t  rd_addr,
    output xform_pkg::vec4_t  rd_data
);
    import xform_pkg::*;

    word_t mem [`XF_RAM_DEPTH];

    // host write port
    always_ff @(posedge clk)
    begin
        if (wr)
        begin
            mem[wr_addr] <= wr_data;
        end
    end

    //////////////////////////////
    // four-word read
    //////////////////////////////
    // addr_t spans the whole depth, so the lane addresses wrap by themselves
    for (genvar k = 0; k < 4; k++)
    begin : g_lane
        addr_t lane_addr;

        assign lane_addr = rd_addr + addr_t'(k);
        assign rd_data[(3 - k) * `XF_WORD_W +: `XF_WORD_W] = mem[lane_addr]; // lowest addr on top
    end

endmodule

`default_nettype wire

/* design/row_dot.sv */
`timescale 1ns/1ps
`default_nettype none

`include "xform_consts.svh"

module row_dot (
    input  xform_pkg::vec4_t  a,
    input  xform_pkg::vec4_t  b,
    output xform_pkg::word_t  result
);
    import xform_pkg::*;

    word_t prod [4];

    // signed lane products, low 32 bits kept
    for (genvar k = 0; k < 4; k++)
    begin : g_mul
        word_t a_k;
        word_t b_k;

        assign a_k     = a[(3 - k) * `XF_WORD_W +: `XF_WORD_W];
        assign b_k     = b[(3 - k) * `XF_WORD_W +: `XF_WORD_W];
        assign prod[k] = a_k * b_k;
    end

    // sum wraps mod 2^32
    assign result = prod[0] + prod[1] + prod[2] + prod[3];

endmodule

`default_nettype wire

/* design/matrix_mul.sv */
`timescale 1ns/1ps
`default_nettype none

`include "xform_consts.svh"

module matrix_mul (
    input  logic                 clk,
    input  logic                 arst_n,
    // operation request
    input  logic                 start,
    input  xform_pkg::op_t       op,
    input  xform_pkg::mode_t     mode,
    input  xform_pkg::addr_t     base_addr,
    // operand RAM
    output xform_pkg::addr_t     ram_addr,
    input  xform_pkg::vec4_t     ram_rdata,
    // matrix register peek
    output xform_pkg::mode_t     peek_mode,
    output xform_pkg::row_idx_t  peek_row,
    input  xform_pkg::vec4_t     peek_data,
    // whole-matrix write back
    output logic                 wr_en,
    output xform_pkg::mode_t     wr_mode,
    output xform_pkg::vec4_t     wr_row_0,
    output xform_pkg::vec4_t     wr_row_1,
    output xform_pkg::vec4_t     wr_row_2,
    output xform_pkg::vec4_t     wr_row_3,
    // status and vertex result
    output xform_pkg::vec4_t     vector_out,
    output logic                 busy,
    output logic                 done
);
    import xform_pkg::*;

    eng_state_t state;
    logic [3:0] elem_cnt;   // matrix: {row, col}, vertex: low bits pick the row
    mode_t      mode_q;
    addr_t      base_q;

    vec4_t      res_q [4];  // M*B result, one row per entry
    vec4_t      eye_q;      // modelview * v
    vec4_t      clip_q;     // staging for vector_out

    row_idx_t   hi_idx;
    row_idx_t   lo_idx;
    vec4_t      vertex;
    vec4_t      dot_b;
    word_t      dot_res;

    // replace element idx of v, element 0 is the top word
    function automatic vec4_t put_elem(vec4_t v, row_idx_t idx, word_t w);
        vec4_t r;
        r = v;
        r[(3 - idx) * `XF_WORD_W +: `XF_WORD_W] = w;
        return r;
    endfunction

    assign hi_idx = elem_cnt[3:2];
    assign lo_idx = elem_cnt[1:0];

    // x, y, z from RAM and w forced to 1
    assign vertex = {ram_rdata[`XF_VEC_W-1:`XF_WORD_W], word_t'(1)};

    //////////////////////////////
    // operand steering
    //////////////////////////////
    always_comb
    begin
        ram_addr  = base_q;
        peek_mode = mode_q;
        peek_row  = lo_idx;
        dot_b     = ram_rdata;
        case (state)
            MAT_RUN:
            begin
                ram_addr = base_q + addr_t'({lo_idx, 2'b00});   // column j at base+4j
                peek_row = hi_idx;
                dot_b    = ram_rdata;
            end
            VTX_EYE:
            begin
                peek_mode = MODE_MODELVIEW;
                dot_b     = vertex;
            end
            VTX_CLIP:
            begin
                peek_mode = MODE_PROJECTION;
                dot_b     = eye_q;
            end
            default:
            begin
            end
        endcase
    end

    // single dot unit shared by every element
    row_dot u_dot (
        .a      (peek_data),
        .b      (dot_b),
        .result (dot_res)
    );

    //////////////////////////////
    // control FSM
    //////////////////////////////
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state      <= IDLE;
            elem_cnt   <= '0;
            mode_q     <= MODE_MODELVIEW;
            base_q     <= '0;
            vector_out <= '0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (start)
                    begin
                        mode_q   <= mode;
                        base_q   <= base_addr;
                        elem_cnt <= '0;
                        state    <= (op == OP_MATRIX) ? MAT_RUN : VTX_EYE;
                    end
                end
                MAT_RUN:
                begin
                    elem_cnt <= elem_cnt + 4'd1;
                    if (elem_cnt == 4'd15)
                    begin
                        state <= MAT_WRITE;   // all 16 elements buffered
                    end
                end
                MAT_WRITE:
                begin
                    state <= IDLE;
                end
                VTX_EYE:
                begin
                    elem_cnt <= elem_cnt + 4'd1;
                    if (lo_idx == 2'd3)
                    begin
                        state <= VTX_CLIP;
                    end
                end
                VTX_CLIP:
                begin
                    elem_cnt <= elem_cnt + 4'd1;
                    if (lo_idx == 2'd3)
                    begin
                        // last clip element joins the staged ones here
                        vector_out <= put_elem(clip_q, lo_idx, dot_res);
                        state      <= VTX_DONE;
                    end
                end
                VTX_DONE:
                begin
                    state <= IDLE;
                end
                default:
                begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // result elements land one per cycle
    always_ff @(posedge clk)
    begin
        case (state)
            MAT_RUN:
            begin
                res_q[hi_idx] <= put_elem(res_q[hi_idx], lo_idx, dot_res);
            end
            VTX_EYE:
            begin
                eye_q <= put_elem(eye_q, lo_idx, dot_res);
            end
            VTX_CLIP:
            begin
                clip_q <= put_elem(clip_q, lo_idx, dot_res);
            end
            default:
            begin
            end
        endcase
    end

    //////////////////////////////
    // outputs
    //////////////////////////////
    assign wr_en    = (state == MAT_WRITE);
    assign wr_mode  = mode_q;
    assign wr_row_0 = res_q[0];
    assign wr_row_1 = res_q[1];
    assign wr_row_2 = res_q[2];
    assign wr_row_3 = res_q[3];

    assign done = (state == MAT_WRITE) || (state == VTX_DONE);
    assign busy = (state != IDLE);   // drops the edge after done

endmodule

`default_nettype wire

/* design/xform_top.sv */
`timescale 1ns/1ps
`default_nettype none

module xform_top (
    input  logic                 clk,
    input  logic                 arst_n,
    // host matrix write
    input  logic                 host_mat_wr,
    input  xform_pkg::mode_t     host_mat_mode,
    input  xform_pkg::row_idx_t  host_mat_row,
    input  xform_pkg::vec4_t     host_mat_data,
    // host matrix readback
    input  xform_pkg::mode_t     host_mat_rd_mode,
    input  xform_pkg::row_idx_t  host_mat_rd_row,
    output xform_pkg::vec4_t     host_mat_rd_data,
    // host RAM write
    input  logic                 host_ram_wr,
    input  xform_pkg::addr_t     host_ram_addr,
    input  xform_pkg::word_t     host_ram_data,
    // operation
    input  logic                 start,
    input  xform_pkg::op_t       op,
    input  xform_pkg::mode_t     mode,
    input  xform_pkg::addr_t     base_addr,
    // status
    output logic                 busy,
    output logic                 done,
    output xform_pkg::vec4_t     vector_out
);
    import xform_pkg::*;

    // engine <-> register block
    mode_t    peek_mode;
    row_idx_t peek_row;
    vec4_t    peek_data;
    logic     wr_en;
    mode_t    wr_mode;
    vec4_t    wr_row_0;
    vec4_t    wr_row_1;
    vec4_t    wr_row_2;
    vec4_t    wr_row_3;

    // engine <-> RAM
    addr_t    ram_addr;
    vec4_t    ram_rdata;

    matrix_regs u_regs (
        .clk       (clk),
        .arst_n    (arst_n),
        .host_wr   (host_mat_wr),
        .host_mode (host_mat_mode),
        .host_row  (host_mat_row),
        .host_data (host_mat_data),
        .rd_mode   (host_mat_rd_mode),
        .rd_row    (host_mat_rd_row),
        .rd_data   (host_mat_rd_data),
        .peek_mode (peek_mode),
        .peek_row  (peek_row),
        .peek_data (peek_data),
        .wr_en     (wr_en),
        .wr_mode   (wr_mode),
        .wr_row_0  (wr_row_0),
        .wr_row_1  (wr_row_1),
        .wr_row_2  (wr_row_2),
        .wr_row_3  (wr_row_3)
    );

    operand_ram u_ram (
        .clk     (clk),
        .wr      (host_ram_wr),
        .wr_addr (host_ram_addr),
        .wr_data (host_ram_data),
        .rd_addr (ram_addr),
        .rd_data (ram_rdata)
    );

    matrix_mul u_engine (
        .clk        (clk),
        .arst_n     (arst_n),
        .start      (start),
        .op         (op),
        .mode       (mode),
        .base_addr  (base_addr),
        .ram_addr   (ram_addr),
        .ram_rdata  (ram_rdata),
        .peek_mode  (peek_mode),
        .peek_row   (peek_row),
        .peek_data  (peek_data),
        .wr_en      (wr_en),
        .wr_mode    (wr_mode),
        .wr_row_0   (wr_row_0),
        .wr_row_1   (wr_row_1),
        .wr_row_2   (wr_row_2),
        .wr_row_3   (wr_row_3),
        .vector_out (vector_out),
        .busy       (busy),
        .done       (done)
    );

endmodule

`default_nettype wire

/* tests/xform_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module xform_assertions (
    input logic                    clk,
    input logic                    arst_n,
    input logic                    start,
    input logic                    busy,
    input logic                    done,
    input logic                    wr_en,
    input xform_pkg::eng_state_t   state,
    input xform_pkg::mode_t        mode_q,
    input xform_pkg::addr_t        base_q
);
    import xform_pkg::*;

    int fail_cnt = 0;   // read by the testbench at the end

    //////////////////////////////
    // engine control timing
    //////////////////////////////
    done_single: assert property (@(posedge clk) disable iff (!arst_n) done |=> !done)
    else
    begin
        $error("done held high for two cycles");
        fail_cnt++;
    end

    wr_with_done: assert property (@(posedge clk) disable iff (!arst_n) wr_en |-> done)
    else
    begin
        $error("wr_en without done");
        fail_cnt++;
    end

    // a running operation keeps its captured operands
    start_ignored: assert property (@(posedge clk) disable iff (!arst_n)
        (start && state != IDLE) |=> (mode_q == $past(mode_q)) && (base_q == $past(base_q)))
    else
    begin
        $error("start during busy changed the running operation");
        fail_cnt++;
    end

    busy_after_done: assert property (@(posedge clk) disable iff (!arst_n) done |=> !busy)
    else
    begin
        $error("busy still high one cycle after done");
        fail_cnt++;
    end

    busy_fall_src: assert property (@(posedge clk) disable iff (!arst_n)
        $fell(busy) |-> $past(done))
    else
    begin
        $error("busy fell without a done in the cycle before");
        fail_cnt++;
    end

endmodule

bind matrix_mul xform_assertions u_asrt (
    .clk    (clk),
    .arst_n (arst_n),
    .start  (start),
    .busy   (busy),
    .done   (done),
    .wr_en  (wr_en),
    .state  (state),
    .mode_q (mode_q),
    .base_q (base_q)
);

`default_nettype wire

/* tests/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic arst_n
);
    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;   // 8 ns period
    end

    // reset held for 5 cycles, released on a falling edge
    initial
    begin
        arst_n = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* tests/xform_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module xform_tb;
    import xform_pkg::*;

    localparam int N_DIRECT   = 12;   // tests 3 to 5
    localparam int N_CHAIN    = 40;
    localparam int OP_CYCLES  = 60;   // one op with RAM setup and readback
    localparam int RUN_CYCLES = 300 + 256 + (N_DIRECT + N_CHAIN) * OP_CYCLES;
    localparam int DONE_LIMIT = 64;

    logic     clk;
    logic     arst_n;
    logic     host_mat_wr;
    mode_t    host_mat_mode;
    row_idx_t host_mat_row;
    vec4_t    host_mat_data;
    mode_t    host_mat_rd_mode;
    row_idx_t host_mat_rd_row;
    vec4_t    host_mat_rd_data;
    logic     host_ram_wr;
    addr_t    host_ram_addr;
    word_t    host_ram_data;
    logic     start;
    op_t      op;
    mode_t    mode;
    addr_t    base_addr;
    logic     busy;
    logic     done;
    vec4_t    vector_out;

    integer   seed = 32'h2d79_a618;
    int       checks = 0;
    int       errors = 0;
    int       err_mark = 0;
    word_t    mdl_mat [2][4][4];   // [mode][row][col]
    word_t    mdl_ram [256];

    tb_clock u_clk (.clk(clk), .arst_n(arst_n));

    xform_top UUT (.*);

    //////////////////////////////
    // helpers
    //////////////////////////////
    function automatic word_t small_val();
        return word_t'(($random(seed) & 127) - 64);   // -64 .. 63
    endfunction

    function automatic vec4_t row_of(int m, int r);
        return {mdl_mat[m][r][0], mdl_mat[m][r][1], mdl_mat[m][r][2], mdl_mat[m][r][3]};
    endfunction

    task automatic check_vec(input vec4_t got, input vec4_t exp, input string what);
        checks++;
        assert (got === exp)
        else
        begin
            errors++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_int(input int got, input int exp, input string what);
        checks++;
        assert (got == exp)
        else
        begin
            errors++;
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic end_test(input int n, input string name);
        $display("test %0d %s finished with %0d errors", n, name, errors - err_mark);
        err_mark = errors;
    endtask

    // all host tasks start and end on a falling edge
    task automatic ram_write(input addr_t a, input word_t d);
        host_ram_wr   = 1'b1;
        host_ram_addr = a;
        host_ram_data = d;
        @(negedge clk);
        host_ram_wr   = 1'b0;
        mdl_ram[a]    = d;
    endtask

    task automatic mat_write(input mode_t m, input row_idx_t r, input vec4_t d);
        host_mat_wr   = 1'b1;
        host_mat_mode = m;
        host_mat_row  = r;
        host_mat_data = d;
        @(negedge clk);
        host_mat_wr   = 1'b0;
        for (int k = 0; k < 4; k++)
            mdl_mat[m][r][k] = word_t'(d[127 - 32 * k -: 32]);
    endtask

    task automatic check_all_rows();
        for (int m = 0; m < 2; m++)
            for (int r = 0; r < 4; r++)
            begin
                host_mat_rd_mode = mode_t'(m);
                host_mat_rd_row  = row_idx_t'(r);
                #1;
                check_vec(host_mat_rd_data, row_of(m, r),
                          $sformatf("readback mode %0d row %0d", m, r));
                @(negedge clk);
            end
    endtask

    //////////////////////////////
    // reference model
    //////////////////////////////
    function automatic void model_matrix_op(input mode_t m, input addr_t b);
        word_t res [4][4];
        addr_t a;
        for (int i = 0; i < 4; i++)
            for (int j = 0; j < 4; j++)
            begin
                res[i][j] = '0;
                for (int k = 0; k < 4; k++)
                begin
                    a = b + addr_t'(4 * j + k);   // column j, wraps at 256
                    res[i][j] += mdl_mat[m][i][k] * mdl_ram[a];
                end
            end
        for (int i = 0; i < 4; i++)
            for (int j = 0; j < 4; j++)
                mdl_mat[m][i][j] = res[i][j];
    endfunction

    function automatic vec4_t model_vertex(input addr_t b);
        word_t v [4];
        word_t eye [4];
        word_t clip [4];
        addr_t a;
        for (int k = 0; k < 3; k++)
        begin
            a = b + addr_t'(k);
            v[k] = mdl_ram[a];
        end
        v[3] = 1;   // w
        for (int i = 0; i < 4; i++)
        begin
            eye[i] = '0;
            for (int k = 0; k < 4; k++)
                eye[i] += mdl_mat[0][i][k] * v[k];
        end
        for (int i = 0; i < 4; i++)
        begin
            clip[i] = '0;
            for (int k = 0; k < 4; k++)
                clip[i] += mdl_mat[1][i][k] * eye[k];
        end
        return {clip[0], clip[1], clip[2], clip[3]};
    endfunction

    // one operation, optionally with stray start pulses while busy
    task automatic run_op(input op_t o, input mode_t m, input addr_t b, input bit noisy);
        int    cyc;
        vec4_t exp_v;
        exp_v = '0;
        if (o == OP_MATRIX)
            model_matrix_op(m, b);
        else
            exp_v = model_vertex(b);
        start     = 1'b1;
        op        = o;
        mode      = m;
        base_addr = b;
        @(negedge clk);
        cyc   = 1;
        start = 1'b0;
        while (!done && cyc < DONE_LIMIT)
        begin
            check_int(busy, 1, "busy during operation");
            if (noisy)
            begin
                start     = $random(seed);
                op        = op_t'($random(seed) & 1);
                mode      = mode_t'($random(seed) & 1);
                base_addr = addr_t'($random(seed));
            end
            @(negedge clk);
            cyc++;
        end
        start = 1'b0;
        assert (done)
        else
        begin
            errors++;
            $display("done never arrived within %0d cycles at %0t", DONE_LIMIT, $time);
        end
        check_int(cyc, (o == OP_MATRIX) ? 17 : 9, "latency");
        if (o == OP_VERTEX)
            check_vec(vector_out, exp_v, "vertex result");
        @(negedge clk);
        check_int(busy, 0, "busy after done");
        if (o == OP_MATRIX)
            check_all_rows();
    endtask

    //////////////////////////////
    // test sequence
    //////////////////////////////
    initial
    begin
        addr_t b;
        int    cnt;
        host_mat_wr      = 1'b0;
        host_mat_mode    = MODE_MODELVIEW;
        host_mat_row     = '0;
        host_mat_data    = '0;
        host_mat_rd_mode = MODE_MODELVIEW;
        host_mat_rd_row  = '0;
        host_ram_wr      = 1'b0;
        host_ram_addr    = '0;
        host_ram_data    = '0;
        start            = 1'b0;
        op               = OP_VERTEX;
        mode             = MODE_MODELVIEW;
        base_addr        = '0;
        for (int m = 0; m < 2; m++)
            for (int i = 0; i < 4; i++)
                for (int j = 0; j < 4; j++)
                    mdl_mat[m][i][j] = (i == j) ? 1 : 0;   // identity after reset
        @(posedge arst_n);
        @(negedge clk);

        check_int(busy, 0, "busy after reset");
        check_int(done, 0, "done after reset");
        check_vec(vector_out, '0, "vector_out after reset");
        check_all_rows();
        end_test(1, "reset state");

        for (int a = 0; a < 256; a++)
            ram_write(addr_t'(a), small_val());   // no stale words in the RAM
        for (int m = 0; m < 2; m++)
            for (int r = 0; r < 4; r++)
                mat_write(mode_t'(m), row_idx_t'(r),
                          {$random(seed), $random(seed), $random(seed), $random(seed)});
        check_all_rows();
        end_test(2, "host register path");

        for (int n = 0; n < 4; n++)
        begin
            b = (n < 2) ? addr_t'($random(seed)) : 8'hFD;   // FD wraps past 255
            for (int k = 0; k < 16; k++)
                ram_write(b + addr_t'(k), small_val());
            run_op(OP_MATRIX, mode_t'(n & 1), b, 1'b0);
        end
        end_test(3, "matrix operation");

        for (int n = 0; n < 4; n++)
        begin
            for (int m = 0; m < 2; m++)
                for (int r = 0; r < 4; r++)
                    mat_write(mode_t'(m), row_idx_t'(r),
                              {small_val(), small_val(), small_val(), small_val()});
            b = addr_t'($random(seed));
            for (int k = 0; k < 3; k++)
                ram_write(b + addr_t'(k), small_val());
            run_op(OP_VERTEX, MODE_MODELVIEW, b, 1'b0);
        end
        end_test(4, "vertex operation");

        for (int n = 0; n < 4; n++)
            run_op(op_t'(n & 1), mode_t'($random(seed) & 1), addr_t'($random(seed)), 1'b1);
        end_test(5, "ignored start");

        for (int n = 0; n < N_CHAIN; n++)
        begin
            cnt = $random(seed) & 7;
            for (int k = 0; k < cnt; k++)
                ram_write(addr_t'($random(seed)), small_val());
            run_op(op_t'($random(seed) & 1), mode_t'($random(seed) & 1),
                   addr_t'($random(seed)), 1'b0);
        end
        check_all_rows();
        end_test(6, "chained sequence");

        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, UUT.u_engine.u_asrt.fail_cnt);
        if (errors == 0 && UUT.u_engine.u_asrt.fail_cnt == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

    // watchdog, twice the expected run length
    initial
    begin
        #(RUN_CYCLES * 2 * 8);
        $display("timeout, the run did not finish in %0d cycles", RUN_CYCLES * 2);
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+include
design/xform_pkg.sv
design/matrix_regs.sv
design/operand_ram.sv
design/row_dot.sv
design/matrix_mul.sv
design/xform_top.sv
tests/xform_assertions.sv
tests/tb_clock.sv
tests/xform_tb.sv
